//--- tinyrv_defs.svh
// ------------------------------------------------
// TinyRV decode-issue sizes
// Register counts and field widths
// ------------------------------------------------

`ifndef TINYRV_DEFS_SVH
`define TINYRV_DEFS_SVH

// Architectural registers x0 to x31
`define NUM_AREGS 32
`define AREG_BITS 5

// Physical registers, at least 33
`define NUM_PHYS_REGS 36
`define PREG_BITS 6

`define SEQ_BITS 8

// Fixed by the routing rule
`define NUM_PIPES 2

`endif

//--- tinyrv_pkg.sv
// ------------------------------------------------
// TinyRV shared types
// Micro-op, immediate format and jump kind enums
// used across decode, routing and issue
// ------------------------------------------------

package tinyrv_pkg;

  // ------------------------------------------------
  // Micro-ops
  // ------------------------------------------------

  // One code per supported instruction
  typedef enum logic [2:0] {
    UOP_ADD  = 3'd0,
    UOP_ADDI = 3'd1,
    UOP_MUL  = 3'd2,
    UOP_LW   = 3'd3,
    UOP_SW   = 3'd4,
    UOP_JAL  = 3'd5,
    UOP_JALR = 3'd6
  } rv_uop;

  // ------------------------------------------------
  // Immediate formats
  // ------------------------------------------------

  // ADDI, LW and JALR use I, SW uses S, JAL uses J
  typedef enum logic [1:0] {
    IMM_I = 2'd0,
    IMM_S = 2'd1,
    IMM_J = 2'd2
  } rv_imm_type;

  // Jump kind, picks the squash target formula
  typedef enum logic [1:0] {
    JUMP_NONE = 2'd0,
    JUMP_JAL  = 2'd1,
    JUMP_JALR = 2'd2
  } rv_jump;

endpackage

//--- inst_decoder.sv
// ------------------------------------------------
// Instruction decoder
// Maps a 32-bit instruction to micro-op, register
// addresses and operand/jump control
// ------------------------------------------------

`include "tinyrv_defs.svh"

module inst_decoder (
  input  logic [31:0]             inst,
  output logic                    val,
  output tinyrv_pkg::rv_uop       uop,
  output logic [`AREG_BITS-1:0]   raddr0,
  output logic [`AREG_BITS-1:0]   raddr1,
  output logic [`AREG_BITS-1:0]   waddr,
  output logic                    wen,
  output tinyrv_pkg::rv_imm_type  imm_sel,
  output logic                    op2_sel,
  output tinyrv_pkg::rv_jump      jump
);

  // Major opcodes
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;
  localparam logic [6:0] OPC_JALR   = 7'b1100111;

  // Instruction fields
  logic [6:0]            opcode;
  logic [2:0]            funct3;
  logic [6:0]            funct7;
  logic [`AREG_BITS-1:0] rs1;
  logic [`AREG_BITS-1:0] rs2;
  logic [`AREG_BITS-1:0] rd;
  logic                  writes;

  assign opcode = inst[6:0];
  assign rd     = inst[11:7];
  assign funct3 = inst[14:12];
  assign rs1    = inst[19:15];
  assign rs2    = inst[24:20];
  assign funct7 = inst[31:25];

  // Unused source ports read x0 so they never stall
  always_comb begin
    val     = 1'b0;
    uop     = tinyrv_pkg::UOP_ADD;
    raddr0  = '0;
    raddr1  = '0;
    writes  = 1'b0;
    imm_sel = tinyrv_pkg::IMM_I;
    op2_sel = 1'b0;
    jump    = tinyrv_pkg::JUMP_NONE;
    case (opcode)
      OPC_OP: begin
        // ADD and MUL share funct3, split on funct7
        if (funct3 == 3'b000 && funct7 == 7'b0000000) begin
          val    = 1'b1;
          uop    = tinyrv_pkg::UOP_ADD;
          raddr0 = rs1;
          raddr1 = rs2;
          writes = 1'b1;
        end else if (funct3 == 3'b000 && funct7 == 7'b0000001) begin
          val    = 1'b1;
          uop    = tinyrv_pkg::UOP_MUL;
          raddr0 = rs1;
          raddr1 = rs2;
          writes = 1'b1;
        end
      end
      OPC_OP_IMM: begin
        if (funct3 == 3'b000) begin
          val     = 1'b1;
          uop     = tinyrv_pkg::UOP_ADDI;
          raddr0  = rs1;
          writes  = 1'b1;
          op2_sel = 1'b1;
        end
      end
      OPC_LOAD: begin
        if (funct3 == 3'b010) begin
          val     = 1'b1;
          uop     = tinyrv_pkg::UOP_LW;
          raddr0  = rs1;
          writes  = 1'b1;
          op2_sel = 1'b1;
        end
      end
      OPC_STORE: begin
        // Base in rs1, store data in rs2
        if (funct3 == 3'b010) begin
          val     = 1'b1;
          uop     = tinyrv_pkg::UOP_SW;
          raddr0  = rs1;
          raddr1  = rs2;
          imm_sel = tinyrv_pkg::IMM_S;
          op2_sel = 1'b1;
        end
      end
      OPC_JAL: begin
        val     = 1'b1;
        uop     = tinyrv_pkg::UOP_JAL;
        writes  = 1'b1;
        imm_sel = tinyrv_pkg::IMM_J;
        jump    = tinyrv_pkg::JUMP_JAL;
      end
      OPC_JALR: begin
        if (funct3 == 3'b000) begin
          val    = 1'b1;
          uop    = tinyrv_pkg::UOP_JALR;
          raddr0 = rs1;
          writes = 1'b1;
          jump   = tinyrv_pkg::JUMP_JALR;
        end
      end
      default: begin
        val = 1'b0;
      end
    endcase
  end

  // Writes to x0 are dropped here and only here
  assign waddr = writes ? rd : '0;
  assign wen   = writes & (rd != '0);

endmodule

//--- imm_gen.sv
// ------------------------------------------------
// Immediate generator
// Sign-extended I, S and J immediates
// ------------------------------------------------

module imm_gen (
  input  logic [31:0]            inst,
  input  tinyrv_pkg::rv_imm_type imm_sel,
  output logic [31:0]            imm
);

  always_comb begin
    case (imm_sel)
      // I type, bits 31:20
      tinyrv_pkg::IMM_I: begin
        imm = {{20{inst[31]}}, inst[31:20]};
      end
      // S type, split across funct7 and rd fields
      tinyrv_pkg::IMM_S: begin
        imm = {{20{inst[31]}}, inst[31:25], inst[11:7]};
      end
      // J type, scrambled, halfword aligned
      tinyrv_pkg::IMM_J: begin
        imm = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
      end
      default: begin
        imm = '0;
      end
    endcase
  end

endmodule

//--- rename_table.sv
// ------------------------------------------------
// Rename table
// Arch-to-phys map, per-preg pending bits and a
// free mask with lowest-first allocation
// ------------------------------------------------

`include "tinyrv_defs.svh"

module rename_table (
  input  logic                  clk,
  input  logic                  rst,

  // Destination allocation
  input  logic [`AREG_BITS-1:0] alloc_areg,
  input  logic                  alloc_en,
  output logic [`PREG_BITS-1:0] alloc_preg,
  output logic [`PREG_BITS-1:0] alloc_ppreg,
  output logic                  alloc_rdy,

  // Source lookup
  input  logic [`AREG_BITS-1:0] lookup_areg0,
  input  logic [`AREG_BITS-1:0] lookup_areg1,
  output logic [`PREG_BITS-1:0] lookup_preg0,
  output logic [`PREG_BITS-1:0] lookup_preg1,
  output logic                  lookup_pending0,
  output logic                  lookup_pending1,

  // Completion
  input  logic                  complete_val,
  input  logic                  complete_wen,
  input  logic [`PREG_BITS-1:0] complete_preg,
  input  logic [`PREG_BITS-1:0] complete_ppreg
);

  logic [`PREG_BITS-1:0]    map [`NUM_AREGS];
  logic [`NUM_PHYS_REGS-1:0] pending;
  logic [`NUM_PHYS_REGS-1:0] free_mask;

  // ------------------------------------------------
  // Combinational lookups
  // ------------------------------------------------

  assign lookup_preg0    = map[lookup_areg0];
  assign lookup_preg1    = map[lookup_areg1];
  assign lookup_pending0 = pending[map[lookup_areg0]];
  assign lookup_pending1 = pending[map[lookup_areg1]];

  assign alloc_ppreg = map[alloc_areg];
  assign alloc_rdy   = |free_mask;

  // Scan from the top down so the lowest free preg wins
  always_comb begin
    alloc_preg = '0;
    for (int i = `NUM_PHYS_REGS - 1; i >= 0; i--) begin
      if (free_mask[i]) begin
        alloc_preg = `PREG_BITS'(i);
      end
    end
  end

  // ------------------------------------------------
  // State update
  // ------------------------------------------------

  // Completion and allocation never touch the same preg
  always_ff @(posedge clk) begin
    if (rst) begin
      // Identity map for x0..x31 with the spares free
      for (int i = 0; i < `NUM_AREGS; i++) begin
        map[i] <= `PREG_BITS'(i);
      end
      pending   <= '0;
      free_mask <= '0;
      for (int i = `NUM_AREGS; i < `NUM_PHYS_REGS; i++) begin
        free_mask[i] <= 1'b1;
      end
    end else begin
      if (complete_val) begin
        if (complete_wen) begin
          pending[complete_preg] <= 1'b0;
        end
        // Previous mapping goes back to the pool
        if (complete_ppreg != '0) begin
          free_mask[complete_ppreg] <= 1'b1;
        end
      end
      // New mapping stays pending until its completion
      if (alloc_en) begin
        map[alloc_areg]       <= alloc_preg;
        pending[alloc_preg]   <= 1'b1;
        free_mask[alloc_preg] <= 1'b0;
      end
    end
  end

endmodule

//--- phys_regfile.sv
// ------------------------------------------------
// Physical register file
// Two async read ports, one sync write port,
// preg 0 hardwired to zero
// ------------------------------------------------

`include "tinyrv_defs.svh"

module phys_regfile #(
  parameter type t_entry = logic [31:0]
) (
  input  logic                  clk,
  input  logic                  rst,
  input  logic [`PREG_BITS-1:0] raddr0,
  input  logic [`PREG_BITS-1:0] raddr1,
  output t_entry                rdata0,
  output t_entry                rdata1,
  input  logic [`PREG_BITS-1:0] waddr,
  input  t_entry                wdata,
  input  logic                  wen
);

  t_entry regs [`NUM_PHYS_REGS];

  // No bypass, new data visible the cycle after the write
  assign rdata0 = regs[raddr0];
  assign rdata1 = regs[raddr1];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < `NUM_PHYS_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wen && waddr != '0) begin
      regs[waddr] <= wdata;
    end
  end

endmodule

//--- issue_router.sv
// ------------------------------------------------
// Issue router
// Picks the execute pipe by micro-op and drives
// the per-pipe valid and the transfer strobe
// ------------------------------------------------

`include "tinyrv_defs.svh"

module issue_router (
  input  tinyrv_pkg::rv_uop     uop,
  input  logic                  val,
  input  logic [`NUM_PIPES-1:0] x_rdy,
  output logic [`NUM_PIPES-1:0] x_val,
  output logic                  xfer
);

  logic pipe_sel;

  // Pipe 0 for ALU and jumps, pipe 1 for MUL and memory
  always_comb begin
    case (uop)
      tinyrv_pkg::UOP_ADD,
      tinyrv_pkg::UOP_ADDI,
      tinyrv_pkg::UOP_JAL,
      tinyrv_pkg::UOP_JALR: begin
        pipe_sel = 1'b0;
      end
      default: begin
        pipe_sel = 1'b1;
      end
    endcase
  end

  // One-hot valid on the chosen pipe only
  always_comb begin
    x_val           = '0;
    x_val[pipe_sel] = val;
  end

  assign xfer = val & x_rdy[pipe_sel];

endmodule

//--- decode_issue_unit.sv
// ------------------------------------------------
// Decode and issue unit
// Decode register, renaming, operand read, stall
// logic, two-pipe issue and jump squash
// ------------------------------------------------

`include "tinyrv_defs.svh"

module decode_issue_unit (
  input  logic                  clk,
  input  logic                  rst,

  // Fetch side
  input  logic                  f_val,
  output logic                  f_rdy,
  input  logic [31:0]           f_inst,
  input  logic [31:0]           f_pc,
  input  logic [`SEQ_BITS-1:0]  f_seq_num,

  // Execute side
  output logic [`NUM_PIPES-1:0] x_val,
  input  logic [`NUM_PIPES-1:0] x_rdy,
  output logic [31:0]           x_pc,
  output logic [31:0]           x_op1,
  output logic [31:0]           x_op2,
  output logic [31:0]           x_mem_data,
  output tinyrv_pkg::rv_uop     x_uop,
  output logic [4:0]            x_waddr,
  output logic [`SEQ_BITS-1:0]  x_seq_num,
  output logic [`PREG_BITS-1:0] x_preg,
  output logic [`PREG_BITS-1:0] x_ppreg,

  // Completion pulse
  input  logic                  complete_val,
  input  logic                  complete_wen,
  input  logic [`PREG_BITS-1:0] complete_preg,
  input  logic [`PREG_BITS-1:0] complete_ppreg,
  input  logic [31:0]           complete_wdata,

  // Squash pulse
  output logic                  squash_val,
  output logic [31:0]           squash_target,
  output logic [`SEQ_BITS-1:0]  squash_seq_num
);

  // ------------------------------------------------
  // Decode register
  // ------------------------------------------------

  logic                 dr_val;
  logic [31:0]          dr_inst;
  logic [31:0]          dr_pc;
  logic [`SEQ_BITS-1:0] dr_seq_num;
  logic                 f_xfer;
  logic                 x_xfer;

  assign f_xfer = f_val & f_rdy;

  // Load wins over clear when both happen
  always_ff @(posedge clk) begin
    if (rst) begin
      dr_val <= 1'b0;
    end else if (f_xfer) begin
      dr_val <= 1'b1;
    end else if (x_xfer) begin
      dr_val <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (f_xfer) begin
      dr_inst    <= f_inst;
      dr_pc      <= f_pc;
      dr_seq_num <= f_seq_num;
    end
  end

  // Empty, or emptying this cycle
  assign f_rdy = ~dr_val | x_xfer;

  // ------------------------------------------------
  // Decode and immediate
  // ------------------------------------------------

  logic                   dec_val;
  tinyrv_pkg::rv_uop      dec_uop;
  logic [4:0]             dec_raddr0;
  logic [4:0]             dec_raddr1;
  logic [4:0]             dec_waddr;
  logic                   dec_wen;
  tinyrv_pkg::rv_imm_type dec_imm_sel;
  logic                   dec_op2_sel;
  tinyrv_pkg::rv_jump     dec_jump;
  logic [31:0]            imm;

  inst_decoder i_inst_decoder (
    .inst    (dr_inst),
    .val     (dec_val),
    .uop     (dec_uop),
    .raddr0  (dec_raddr0),
    .raddr1  (dec_raddr1),
    .waddr   (dec_waddr),
    .wen     (dec_wen),
    .imm_sel (dec_imm_sel),
    .op2_sel (dec_op2_sel),
    .jump    (dec_jump)
  );

  imm_gen i_imm_gen (
    .inst    (dr_inst),
    .imm_sel (dec_imm_sel),
    .imm     (imm)
  );

  // ------------------------------------------------
  // Rename and operand read
  // ------------------------------------------------

  logic [`PREG_BITS-1:0] alloc_preg;
  logic [`PREG_BITS-1:0] alloc_ppreg;
  logic                  alloc_rdy;
  logic                  alloc_en;
  logic [`PREG_BITS-1:0] src_preg0;
  logic [`PREG_BITS-1:0] src_preg1;
  logic                  src_pending0;
  logic                  src_pending1;
  logic [31:0]           rdata0;
  logic [31:0]           rdata1;

  // Only a writer that actually issues takes a preg
  assign alloc_en = x_xfer & dec_wen;

  rename_table i_rename_table (
    .clk             (clk),
    .rst             (rst),
    .alloc_areg      (dec_waddr),
    .alloc_en        (alloc_en),
    .alloc_preg      (alloc_preg),
    .alloc_ppreg     (alloc_ppreg),
    .alloc_rdy       (alloc_rdy),
    .lookup_areg0    (dec_raddr0),
    .lookup_areg1    (dec_raddr1),
    .lookup_preg0    (src_preg0),
    .lookup_preg1    (src_preg1),
    .lookup_pending0 (src_pending0),
    .lookup_pending1 (src_pending1),
    .complete_val    (complete_val),
    .complete_wen    (complete_wen),
    .complete_preg   (complete_preg),
    .complete_ppreg  (complete_ppreg)
  );

  phys_regfile #(
    .t_entry (logic [31:0])
  ) i_phys_regfile (
    .clk    (clk),
    .rst    (rst),
    .raddr0 (src_preg0),
    .raddr1 (src_preg1),
    .rdata0 (rdata0),
    .rdata1 (rdata1),
    .waddr  (complete_preg),
    .wdata  (complete_wdata),
    .wen    (complete_val & complete_wen)
  );

  // ------------------------------------------------
  // Stall and issue
  // ------------------------------------------------

  logic stall;
  logic issue_val;

  // RAW on either source, or a writer with no free preg
  assign stall     = src_pending0 | src_pending1 | (dec_wen & ~alloc_rdy);
  assign issue_val = dr_val & dec_val & ~stall;

  issue_router i_issue_router (
    .uop   (dec_uop),
    .val   (issue_val),
    .x_rdy (x_rdy),
    .x_val (x_val),
    .xfer  (x_xfer)
  );

  // Shared execute fields
  assign x_pc       = dr_pc;
  assign x_op1      = rdata0;
  assign x_op2      = dec_op2_sel ? imm : rdata1;
  assign x_mem_data = rdata1;
  assign x_uop      = dec_uop;
  assign x_waddr    = dec_waddr;
  assign x_seq_num  = dr_seq_num;
  // Non-writers carry preg 0 so their completion is harmless
  assign x_preg     = dec_wen ? alloc_preg : '0;
  assign x_ppreg    = alloc_ppreg;

  // ------------------------------------------------
  // Jump squash
  // ------------------------------------------------

  logic [31:0] jump_target;

  always_comb begin
    case (dec_jump)
      tinyrv_pkg::JUMP_JAL: begin
        jump_target = dr_pc + imm;
      end
      // JALR clears the low bit
      tinyrv_pkg::JUMP_JALR: begin
        jump_target = (rdata0 + imm) & 32'hffff_fffe;
      end
      default: begin
        jump_target = '0;
      end
    endcase
  end

  // Pulse only in the jump's issue cycle
  assign squash_val     = x_xfer & (dec_jump != tinyrv_pkg::JUMP_NONE);
  assign squash_target  = jump_target;
  assign squash_seq_num = dr_seq_num;

endmodule

//--- tb_decode_issue_unit.sv
// ------------------------------------------------
// Decode-issue unit testbench
// Random program, execute and completion model,
// in-order reference model with a rename shadow
// ------------------------------------------------

`include "tinyrv_defs.svh"

module tb_decode_issue_unit;

  timeunit 1ns;
  timeprecision 100ps;

  localparam int NUM_PROG   = 420;
  localparam int NUM_ISSUES = 400;

  // One outstanding writer in the execute model
  typedef struct {
    logic [`PREG_BITS-1:0] preg;
    logic [`PREG_BITS-1:0] ppreg;
    logic [31:0]           data;
    int                    due;
  } cmpl_t;

  logic                  clk = 1'b0;
  logic                  rst = 1'b1;
  logic                  f_val = 1'b0;
  logic                  f_rdy;
  logic [31:0]           f_inst = '0;
  logic [31:0]           f_pc = '0;
  logic [`SEQ_BITS-1:0]  f_seq_num = '0;
  logic [`NUM_PIPES-1:0] x_val;
  logic [`NUM_PIPES-1:0] x_rdy = '0;
  logic [31:0]           x_pc;
  logic [31:0]           x_op1;
  logic [31:0]           x_op2;
  logic [31:0]           x_mem_data;
  tinyrv_pkg::rv_uop     x_uop;
  logic [4:0]            x_waddr;
  logic [`SEQ_BITS-1:0]  x_seq_num;
  logic [`PREG_BITS-1:0] x_preg;
  logic [`PREG_BITS-1:0] x_ppreg;
  logic                  complete_val = 1'b0;
  logic                  complete_wen = 1'b0;
  logic [`PREG_BITS-1:0] complete_preg = '0;
  logic [`PREG_BITS-1:0] complete_ppreg = '0;
  logic [31:0]           complete_wdata = '0;
  logic                  squash_val;
  logic [31:0]           squash_target;
  logic [`SEQ_BITS-1:0]  squash_seq_num;

  // Program with decoded fields kept next to the encoding
  tinyrv_pkg::rv_uop p_uop [NUM_PROG];
  logic [31:0]       p_inst [NUM_PROG];
  logic [4:0]        p_rd [NUM_PROG];
  logic [4:0]        p_rs1 [NUM_PROG];
  logic [4:0]        p_rs2 [NUM_PROG];
  logic [31:0]       p_imm [NUM_PROG];

  // Reference model and rename shadow
  logic [31:0]               arf [32];
  logic [`PREG_BITS-1:0]     smap [32];
  logic [`NUM_PHYS_REGS-1:0] held;
  cmpl_t                     cq [$];
  logic [31:0]               lcg_state;
  int                        issue_count = 0;
  int                        fetch_idx = 0;
  int                        cycle = 0;
  logic                      running = 1'b0;

  decode_issue_unit i_decode_issue_unit (.*);

  always #2 clk = ~clk;

  // ------------------------------------------------
  // Helpers
  // ------------------------------------------------

  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // Load data as a hash of the whole address
  function automatic logic [31:0] mem_word(input logic [31:0] addr);
    return (addr * 32'h9e37_79b9) ^ 32'h5bd1_e995;
  endfunction

  // ALU and jumps go to pipe 0 and MUL and memory to pipe 1
  function automatic logic [1:0] pipe_mask(input tinyrv_pkg::rv_uop uop);
    case (uop)
      tinyrv_pkg::UOP_ADD, tinyrv_pkg::UOP_ADDI,
      tinyrv_pkg::UOP_JAL, tinyrv_pkg::UOP_JALR: return 2'b01;
      default: return 2'b10;
    endcase
  endfunction

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("Regression failed");
    $fatal(1);
  endtask

  task automatic check_eq(input string name, input logic [31:0] exp, input logic [31:0] act);
    assert (act === exp)
      else fail_run($sformatf("CHECK FAILED %s: expected %h, actual %h", name, exp, act));
  endtask

  // Random program over x0..x7 with small immediates
  task automatic build_program();
    logic [31:0] r;
    logic [31:0] s;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [11:0] i12;
    logic [20:0] j21;
    for (int n = 0; n < NUM_PROG; n++) begin
      r   = next_rand();
      s   = next_rand();
      rd  = {2'b00, r[26:24]};
      rs1 = {2'b00, r[23:21]};
      rs2 = {2'b00, s[31:29]};
      i12 = {{7{s[28]}}, s[28:24]};
      j21 = {{15{s[28]}}, s[28:24], 1'b0};
      p_uop[n] = tinyrv_pkg::rv_uop'(3'(r[31:27] % 7));
      p_rd[n]  = rd;
      p_rs1[n] = rs1;
      p_rs2[n] = rs2;
      p_imm[n] = {{20{i12[11]}}, i12};
      case (p_uop[n])
        tinyrv_pkg::UOP_ADD:  p_inst[n] = {7'b0000000, rs2, rs1, 3'b000, rd, 7'b0110011};
        tinyrv_pkg::UOP_MUL:  p_inst[n] = {7'b0000001, rs2, rs1, 3'b000, rd, 7'b0110011};
        tinyrv_pkg::UOP_ADDI: p_inst[n] = {i12, rs1, 3'b000, rd, 7'b0010011};
        tinyrv_pkg::UOP_LW:   p_inst[n] = {i12, rs1, 3'b010, rd, 7'b0000011};
        tinyrv_pkg::UOP_SW:   p_inst[n] = {i12[11:5], rs2, rs1, 3'b010, i12[4:0], 7'b0100011};
        tinyrv_pkg::UOP_JALR: p_inst[n] = {i12, rs1, 3'b000, rd, 7'b1100111};
        default: begin
          p_inst[n] = {j21[20], j21[10:1], j21[11], j21[19:12], rd, 7'b1101111};
          p_imm[n]  = {{11{j21[20]}}, j21};
        end
      endcase
    end
  endtask

  // ------------------------------------------------
  // Issue checks and reference update
  // ------------------------------------------------

  task automatic check_issue();
    tinyrv_pkg::rv_uop uop;
    logic [31:0]       a;
    logic [31:0]       b;
    logic [31:0]       imm;
    logic [31:0]       pc;
    logic [31:0]       result;
    logic [4:0]        rd;
    logic              writer;
    cmpl_t             c;
    uop = p_uop[issue_count];
    rd  = p_rd[issue_count];
    imm = p_imm[issue_count];
    pc  = 32'(issue_count) * 4;
    // JAL has no source and only R-type and SW read rs2
    a = (uop != tinyrv_pkg::UOP_JAL) ? arf[p_rs1[issue_count]] : '0;
    b = (uop == tinyrv_pkg::UOP_ADD || uop == tinyrv_pkg::UOP_MUL ||
         uop == tinyrv_pkg::UOP_SW) ? arf[p_rs2[issue_count]] : '0;
    writer = (uop != tinyrv_pkg::UOP_SW) && (rd != '0);
    check_eq("issue seq_num", 32'(issue_count % 256), 32'(x_seq_num));
    check_eq("issue pc", pc, x_pc);
    check_eq("issue uop", 32'(uop), 32'(x_uop));
    check_eq("issue op1", a, x_op1);
    check_eq("issue op2", (uop == tinyrv_pkg::UOP_ADDI || uop == tinyrv_pkg::UOP_LW ||
                           uop == tinyrv_pkg::UOP_SW) ? imm : b, x_op2);
    check_eq("issue mem_data", b, x_mem_data);
    check_eq("issue waddr", (uop == tinyrv_pkg::UOP_SW) ? 32'd0 : 32'(rd), 32'(x_waddr));
    case (uop)
      tinyrv_pkg::UOP_ADD:  result = a + b;
      tinyrv_pkg::UOP_ADDI: result = a + imm;
      tinyrv_pkg::UOP_MUL:  result = a * b;
      tinyrv_pkg::UOP_LW:   result = mem_word(a + imm);
      default:              result = pc + 32'd4;
    endcase
    if (uop == tinyrv_pkg::UOP_JAL) begin
      check_eq("squash target jal", pc + imm, squash_target);
    end
    if (uop == tinyrv_pkg::UOP_JALR) begin
      check_eq("squash target jalr", (a + imm) & ~32'd1, squash_target);
    end
    if (squash_val) begin
      check_eq("squash seq_num", 32'(issue_count % 256), 32'(squash_seq_num));
    end
    if (writer) begin
      check_eq("rename ppreg", 32'(smap[rd]), 32'(x_ppreg));
      assert ($countones(~held) > 0)
        else fail_run("writer issued while every spare physical register was held");
      assert (x_preg != '0 && x_preg < `NUM_PHYS_REGS && !held[x_preg])
        else fail_run($sformatf("destination preg %0d is already in use", x_preg));
      held[x_preg] = 1'b1;
      smap[rd]     = x_preg;
      arf[rd]      = result;
      c.preg       = x_preg;
      c.ppreg      = x_ppreg;
      c.data       = result;
      // Completes 1 to 6 cycles later
      c.due        = cycle + int'(next_rand() % 6);
      cq.push_back(c);
    end
    issue_count = issue_count + 1;
  endtask

  // ------------------------------------------------
  // Fetch, execute-pipe and completion drivers
  // ------------------------------------------------

  task automatic drive_inputs(input logic live, input logic f_fire);
    logic [31:0] r;
    logic        blocked;
    int          pick;
    complete_val = 1'b0;
    complete_wen = 1'b0;
    if (!live) begin
      f_val = 1'b0;
      x_rdy = '0;
    end else begin
      r = next_rand();
      // Hold fetch fields until taken
      if (!(f_val && !f_fire)) begin
        f_val = (fetch_idx < NUM_PROG) && (r[31:29] != 3'd0);
        if (fetch_idx < NUM_PROG) begin
          f_inst    = p_inst[fetch_idx];
          f_pc      = 32'(fetch_idx) * 4;
          f_seq_num = `SEQ_BITS'(fetch_idx);
        end
      end
      x_rdy = {r[27:26] != 2'd0, r[25:24] != 2'd0};
      // Oldest due writer whose old preg is no longer awaited
      pick = -1;
      for (int i = 0; i < cq.size(); i++) begin
        blocked = 1'b0;
        for (int j = 0; j < i; j++) begin
          if (cq[j].preg == cq[i].ppreg) begin
            blocked = 1'b1;
          end
        end
        if (pick < 0 && cq[i].due <= cycle && !blocked) begin
          pick = i;
        end
      end
      if (pick >= 0) begin
        complete_val   = 1'b1;
        complete_wen   = 1'b1;
        complete_preg  = cq[pick].preg;
        complete_ppreg = cq[pick].ppreg;
        complete_wdata = cq[pick].data;
        cq.delete(pick);
      end
    end
  endtask

  // Sample at the edge and drive just after it
  always @(posedge clk) begin
    logic live;
    logic f_fire;
    live   = running & ~rst;
    f_fire = f_val & f_rdy;
    cycle  = cycle + 1;
    if (live && |(x_val & x_rdy)) begin
      check_issue();
    end
    if (live && complete_val && complete_ppreg != '0) begin
      held[complete_ppreg] = 1'b0;
    end
    if (live && f_fire) begin
      fetch_idx = fetch_idx + 1;
    end
    #1;
    drive_inputs(live, f_fire);
  end

  // ------------------------------------------------
  // Handshake, routing and squash properties
  // ------------------------------------------------

  logic x_stalled;
  logic jump_issue;

  assign x_stalled  = |(x_val & ~x_rdy);
  assign jump_issue = |(x_val & x_rdy) &&
                      (x_uop == tinyrv_pkg::UOP_JAL || x_uop == tinyrv_pkg::UOP_JALR);

  a_one_pipe: assert property (@(posedge clk) disable iff (rst) $onehot0(x_val))
    else fail_run("more than one x_val is high");

  a_route: assert property (@(posedge clk) disable iff (rst)
      |x_val |-> x_val == pipe_mask(x_uop))
    else fail_run($sformatf("CHECK FAILED routing: expected %b, actual %b",
                            pipe_mask($sampled(x_uop)), $sampled(x_val)));

  // x_preg may move to a lower preg freed while waiting
  a_hold: assert property (@(posedge clk) disable iff (rst)
      x_stalled |=> x_val == $past(x_val) && $stable({x_pc, x_op1, x_op2, x_mem_data,
                                            x_uop, x_waddr, x_seq_num, x_ppreg}))
    else fail_run("execute fields changed while the selected pipe was not ready");

  a_blocked: assert property (@(posedge clk) disable iff (rst)
      x_stalled |-> !f_rdy && !squash_val)
    else fail_run("f_rdy or squash_val high while issue was back-pressured");

  // A taken issue frees the decode register for the next fetch
  a_refill: assert property (@(posedge clk) disable iff (rst)
      |(x_val & x_rdy) |-> f_rdy)
    else fail_run("f_rdy low in a cycle with an issue transfer");

  a_squash: assert property (@(posedge clk) disable iff (rst) squash_val == jump_issue)
    else fail_run("squash pulse does not line up with a jump issue");

  // ------------------------------------------------
  // Reset, run and end of test
  // ------------------------------------------------

  initial begin
    int idle;
    int last_count;
    int cycles;
    lcg_state = 32'h4b8b0358;
    for (int i = 0; i < 32; i++) begin
      arf[i]  = '0;
      smap[i] = `PREG_BITS'(i);
    end
    held = {{(`NUM_PHYS_REGS - 32){1'b0}}, {32{1'b1}}};
    build_program();
    repeat (10) @(posedge clk);
    #1;
    rst = 1'b0;
    // Idle outputs until the first fetch
    repeat (4) begin
      @(negedge clk);
      check_eq("reset x_val", 32'd0, 32'(x_val));
      check_eq("reset squash_val", 32'd0, 32'(squash_val));
      check_eq("reset f_rdy", 32'd1, 32'(f_rdy));
    end
    @(posedge clk);
    #1;
    running    = 1'b1;
    idle       = 0;
    cycles     = 0;
    last_count = 0;
    while (issue_count < NUM_ISSUES && idle < 200 && cycles < 20000) begin
      @(posedge clk);
      #1;
      cycles = cycles + 1;
      if (issue_count != last_count) begin
        idle       = 0;
        last_count = issue_count;
      end else begin
        idle = idle + 1;
      end
    end
    if (issue_count >= NUM_ISSUES) begin
      $display("Regression passed");
      $finish;
    end else begin
      fail_run($sformatf("timed out after %0d issues, %0d cycles without an issue",
                         issue_count, idle));
    end
  end

endmodule

//--- decode_issue_unit.f
+incdir+.
tinyrv_pkg.sv
inst_decoder.sv
imm_gen.sv
rename_table.sv
phys_regfile.sv
issue_router.sv
decode_issue_unit.sv
tb_decode_issue_unit.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the decode-issue testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_decode_issue_unit \
  -f decode_issue_unit.f -o sim_tb > build.log 2>&1
if [ $? -ne 0 ]; then
  cat build.log
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
status=$?
cat sim.log

if grep -q "Regression failed" sim.log; then
  exit 1
fi
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi
exit 0
